//--- hdl/cpu_pkg.sv
package cpu_pkg;

  // ************************************************************
  // widths and memory sizes
  // ************************************************************
  localparam int DATA_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 8;   // word address of both memories and the pc
  localparam int REGISTER_WIDTH = 5;
  localparam int OPCODE_WIDTH   = 6;
  localparam int IMEM_SIZE      = 64;
  localparam int DMEM_SIZE      = 64;
  localparam int IMM_WIDTH      = 16;

  // ************************************************************
  // opcodes
  // ************************************************************
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_ADDI = 6'd5,
    OP_LW   = 6'd6,
    OP_SW   = 6'd7,
    OP_BEQ  = 6'd8,
    OP_JMP  = 6'd9   // absolute target held in imm
  } opcode_e;

  // ************************************************************
  // instruction word, seen as register or immediate format
  // ************************************************************
  typedef union packed {
    struct packed {
      opcode_e                   opcode;
      logic [REGISTER_WIDTH-1:0] rd;
      logic [REGISTER_WIDTH-1:0] ra;
      logic [REGISTER_WIDTH-1:0] rb;
      logic [10:0]               unused;
    } r;
    struct packed {
      opcode_e                   opcode;
      logic [REGISTER_WIDTH-1:0] rd;      // second source for sw and beq
      logic [REGISTER_WIDTH-1:0] ra;
      logic [IMM_WIDTH-1:0]      imm;
    } i;
  } instruction_t;

endpackage

//--- hdl/cpu_intf.sv
interface exec_bus_if;
  import cpu_pkg::*;

  logic                      valid;
  logic [ADDR_WIDTH-1:0]     pc;
  opcode_e                   opcode;
  logic [DATA_WIDTH-1:0]     reg_a_data;
  logic [DATA_WIDTH-1:0]     reg_b_data;
  logic [DATA_WIDTH-1:0]     imm_ext;
  logic [REGISTER_WIDTH-1:0] wr_reg;
  logic                      wr_en;

  modport producer (output valid, pc, opcode, reg_a_data, reg_b_data, imm_ext, wr_reg, wr_en);
  modport consumer (input  valid, pc, opcode, reg_a_data, reg_b_data, imm_ext, wr_reg, wr_en);

endinterface

interface mem_bus_if;
  import cpu_pkg::*;

  logic                      valid;
  logic [ADDR_WIDTH-1:0]     pc;
  logic [DATA_WIDTH-1:0]     alu_result;   // also the data memory address
  logic [DATA_WIDTH-1:0]     store_data;
  logic [REGISTER_WIDTH-1:0] wr_reg;
  logic                      wr_en;
  logic                      is_load;
  logic                      is_store;

  modport producer (output valid, pc, alu_result, store_data, wr_reg, wr_en, is_load, is_store);
  modport consumer (input  valid, pc, alu_result, store_data, wr_reg, wr_en, is_load, is_store);

endinterface

//--- hdl/fetch_stage.sv
module fetch_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          imem_we_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] imem_addr_i,
  input  cpu_pkg::instruction_t         imem_data_i,
  input  logic                          redirect_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
  output logic                          valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] pc_o,
  output cpu_pkg::instruction_t         instr_o
);
  import cpu_pkg::*;

  instruction_t          imem [0:IMEM_SIZE-1];
  logic [ADDR_WIDTH-1:0] pc_q;

  // ************************************************************
  // instruction memory, loaded by the testbench during reset
  // ************************************************************
  always_ff @(posedge clk_i) begin
    if (imem_we_i && !rst_i) begin
      imem[imem_addr_i[$clog2(IMEM_SIZE)-1:0]] <= imem_data_i;
    end
  end

  // program counter and fetch valid
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q    <= '0;
      valid_o <= 1'b0;
    end else if (redirect_i) begin
      pc_q    <= redirect_pc_i;   // target is fetched on the next edge
      valid_o <= 1'b0;            // drop the word fetched behind the branch
    end else begin
      pc_q    <= pc_q + 1'b1;
      valid_o <= 1'b1;
    end
  end

  // fetched word and its pc, qualified by valid_o
  always_ff @(posedge clk_i) begin
    instr_o <= imem[pc_q[$clog2(IMEM_SIZE)-1:0]];
    pc_o    <= pc_q;
  end

  // program loading must be finished before the core leaves reset
  a_imem_load_in_reset : assert property (
    @(posedge clk_i) rst_i |-> !imem_we_i
  ) else $error("instruction memory written outside reset");

endmodule

//--- hdl/decode_stage.sv
module decode_stage (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              valid_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     pc_i,
  input  cpu_pkg::instruction_t             instr_i,
  input  logic                              redirect_i,
  output logic [cpu_pkg::REGISTER_WIDTH-1:0] rd_a_o,
  output logic [cpu_pkg::REGISTER_WIDTH-1:0] rd_b_o,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     reg_a_data_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     reg_b_data_i,
  exec_bus_if.producer                      ex
);
  import cpu_pkg::*;

  opcode_e                   opcode;
  logic                      i_view;       // immediate format selected
  logic                      writes_reg;
  logic [REGISTER_WIDTH-1:0] wr_reg;
  logic [DATA_WIDTH-1:0]     imm_ext;

  assign opcode = instr_i.r.opcode;

  always_comb begin
    i_view     = 1'b0;
    writes_reg = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR: writes_reg = 1'b1;
      OP_ADDI, OP_LW: begin
        i_view     = 1'b1;
        writes_reg = 1'b1;
      end
      OP_SW, OP_BEQ, OP_JMP: i_view = 1'b1;
      default: ;
    endcase
  end

  // ************************************************************
  // register read request and immediate
  // ************************************************************
  assign rd_a_o  = i_view ? instr_i.i.ra : instr_i.r.ra;
  assign rd_b_o  = i_view ? instr_i.i.rd : instr_i.r.rb;    // rd is a source for sw and beq
  assign wr_reg  = i_view ? instr_i.i.rd : instr_i.r.rd;
  assign imm_ext = i_view ? {{(DATA_WIDTH-IMM_WIDTH){instr_i.i.imm[IMM_WIDTH-1]}}, instr_i.i.imm}
                          : '0;

  // decode output register
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ex.valid <= 1'b0;
      ex.wr_en <= 1'b0;
    end else begin
      ex.valid <= valid_i && !redirect_i;   // second squashed slot
      ex.wr_en <= writes_reg;
    end
  end

  always_ff @(posedge clk_i) begin
    ex.pc         <= pc_i;
    ex.opcode     <= opcode;
    ex.reg_a_data <= reg_a_data_i;
    ex.reg_b_data <= reg_b_data_i;
    ex.imm_ext    <= imm_ext;
    ex.wr_reg     <= wr_reg;
  end

endmodule

//--- hdl/rbank.sv
module rbank (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              wr_en_i,
  input  logic [cpu_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wr_data_i,
  input  logic [cpu_pkg::REGISTER_WIDTH-1:0] rd_a_i,
  input  logic [cpu_pkg::REGISTER_WIDTH-1:0] rd_b_i,
  input  logic [cpu_pkg::REGISTER_WIDTH-1:0] dbg_sel_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     reg_a_data_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     reg_b_data_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_data_o
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0] regs [0:(1<<REGISTER_WIDTH)-1];

  // a read of the register under write sees the new value
  function automatic logic [DATA_WIDTH-1:0] read_port(input logic [REGISTER_WIDTH-1:0] idx);
    if (wr_en_i && wr_reg_i == idx && idx != '0) return wr_data_i;
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < (1 << REGISTER_WIDTH); i++) regs[i] <= '0;
    end else if (wr_en_i && wr_reg_i != '0) begin   // r0 stays zero
      regs[wr_reg_i] <= wr_data_i;
    end
  end

  always_comb begin
    reg_a_data_o = read_port(rd_a_i);
    reg_b_data_o = read_port(rd_b_i);
  end

  assign dbg_data_o = regs[dbg_sel_i];

  a_wr_reg_known : assert property (
    @(posedge clk_i) disable iff (!rst_i) wr_en_i |-> !$isunknown(wr_reg_i)
  ) else $error("register write with unknown index");

endmodule

//--- hdl/alu_stage.sv
module alu_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  exec_bus_if.consumer                  ex,
  output logic                          redirect_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] redirect_pc_o,
  mem_bus_if.producer                   mem
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0] result;
  logic                  operands_equal;
  logic                  is_load;
  logic                  is_store;
  logic                  take;

  // ************************************************************
  // arithmetic and address generation
  // ************************************************************
  always_comb begin
    case (ex.opcode)
      OP_ADD:                 result = ex.reg_a_data + ex.reg_b_data;
      OP_SUB:                 result = ex.reg_a_data - ex.reg_b_data;
      OP_AND:                 result = ex.reg_a_data & ex.reg_b_data;
      OP_OR:                  result = ex.reg_a_data | ex.reg_b_data;
      OP_ADDI, OP_LW, OP_SW:  result = ex.reg_a_data + ex.imm_ext;  // sum is the word address
      default:                result = '0;
    endcase
  end

  assign is_load        = ex.opcode == OP_LW;
  assign is_store       = ex.opcode == OP_SW;
  assign operands_equal = ex.reg_a_data == ex.reg_b_data;

  // ************************************************************
  // branch and jump resolution
  // ************************************************************
  always_comb begin
    take          = 1'b0;
    redirect_pc_o = ex.imm_ext[ADDR_WIDTH-1:0];   // absolute jump target
    case (ex.opcode)
      OP_JMP: take = 1'b1;
      OP_BEQ: begin
        take          = operands_equal;
        redirect_pc_o = ex.pc + ADDR_WIDTH'(1) + ex.imm_ext[ADDR_WIDTH-1:0];
      end
      default: ;
    endcase
  end

  assign redirect_o = ex.valid && take;

  // execute output register, the branch itself still retires
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem.valid    <= 1'b0;
      mem.wr_en    <= 1'b0;
      mem.is_load  <= 1'b0;
      mem.is_store <= 1'b0;
    end else begin
      mem.valid    <= ex.valid;
      mem.wr_en    <= ex.wr_en;
      mem.is_load  <= is_load;
      mem.is_store <= is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    mem.pc         <= ex.pc;
    mem.alu_result <= result;
    mem.store_data <= ex.reg_b_data;
    mem.wr_reg     <= ex.wr_reg;
  end

  // decode drops the word behind a redirect, so the pulse lasts one cycle
  a_redirect_squashes_next : assert property (
    @(posedge clk_i) disable iff (!rst_i) redirect_o |=> !ex.valid
  ) else $error("instruction behind a redirect reached execute");

endmodule

//--- hdl/mem_wb_stage.sv
module mem_wb_stage (
  input  logic                              clk_i,
  input  logic                              rst_i,
  mem_bus_if.consumer                       mem,
  output logic                              wr_en_o,
  output logic [cpu_pkg::REGISTER_WIDTH-1:0] wr_reg_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     wr_data_o,
  output logic                              retire_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     retire_pc_o,
  output logic                              store_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     store_addr_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     store_data_o
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0]          dmem [0:DMEM_SIZE-1];
  logic [$clog2(DMEM_SIZE)-1:0]   dmem_idx;
  logic [DATA_WIDTH-1:0]          load_data;

  assign dmem_idx  = mem.alu_result[$clog2(DMEM_SIZE)-1:0];
  assign load_data = dmem[dmem_idx];

  // ************************************************************
  // data memory
  // ************************************************************
  always_ff @(posedge clk_i) begin
    if (mem.valid && mem.is_store) begin
      dmem[dmem_idx] <= mem.store_data;
    end
  end

  // write-back select
  assign wr_en_o   = mem.valid && mem.wr_en;
  assign wr_reg_o  = mem.wr_reg;
  assign wr_data_o = mem.is_load ? load_data : mem.alu_result;

  assign retire_o     = mem.valid;   // one pulse per surviving instruction
  assign retire_pc_o  = mem.pc;
  assign store_o      = mem.valid && mem.is_store;
  assign store_addr_o = mem.alu_result[ADDR_WIDTH-1:0];
  assign store_data_o = mem.store_data;

  a_dmem_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_i)
      (mem.valid && (mem.is_load || mem.is_store)) |-> (mem.alu_result < DMEM_SIZE)
  ) else $error("data memory access out of range");

endmodule

//--- hdl/cpu.sv
module cpu (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              imem_we_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     imem_addr_i,
  input  cpu_pkg::instruction_t             imem_data_i,
  input  logic [cpu_pkg::REGISTER_WIDTH-1:0] dbg_reg_sel_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_reg_data_o,
  output logic                              retire_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     retire_pc_o,
  output logic                              store_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     store_addr_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     store_data_o
);
  import cpu_pkg::*;

  // ************************************************************
  // stage wiring
  // ************************************************************
  logic                      fetch_valid;
  logic [ADDR_WIDTH-1:0]     fetch_pc;
  instruction_t              fetch_instr;

  logic                      redirect;
  logic [ADDR_WIDTH-1:0]     redirect_pc;

  logic [REGISTER_WIDTH-1:0] rd_a;
  logic [REGISTER_WIDTH-1:0] rd_b;
  logic [DATA_WIDTH-1:0]     reg_a_data;
  logic [DATA_WIDTH-1:0]     reg_b_data;

  logic                      wb_wr_en;
  logic [REGISTER_WIDTH-1:0] wb_wr_reg;
  logic [DATA_WIDTH-1:0]     wb_wr_data;

  exec_bus_if ex_bus ();
  mem_bus_if  mem_bus ();

  fetch_stage fetch_stage0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .imem_we_i     (imem_we_i),
    .imem_addr_i   (imem_addr_i),
    .imem_data_i   (imem_data_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .valid_o       (fetch_valid),
    .pc_o          (fetch_pc),
    .instr_o       (fetch_instr)
  );

  decode_stage decode_stage0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (fetch_valid),
    .pc_i         (fetch_pc),
    .instr_i      (fetch_instr),
    .redirect_i   (redirect),
    .rd_a_o       (rd_a),
    .rd_b_o       (rd_b),
    .reg_a_data_i (reg_a_data),
    .reg_b_data_i (reg_b_data),
    .ex           (ex_bus.producer)
  );

  rbank rbank0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (wb_wr_en),
    .wr_reg_i     (wb_wr_reg),
    .wr_data_i    (wb_wr_data),
    .rd_a_i       (rd_a),
    .rd_b_i       (rd_b),
    .dbg_sel_i    (dbg_reg_sel_i),
    .reg_a_data_o (reg_a_data),
    .reg_b_data_o (reg_b_data),
    .dbg_data_o   (dbg_reg_data_o)
  );

  alu_stage alu_stage0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ex            (ex_bus.consumer),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .mem           (mem_bus.producer)
  );

  mem_wb_stage mem_wb_stage0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mem          (mem_bus.consumer),
    .wr_en_o      (wb_wr_en),
    .wr_reg_o     (wb_wr_reg),
    .wr_data_o    (wb_wr_data),
    .retire_o     (retire_o),
    .retire_pc_o  (retire_pc_o),
    .store_o      (store_o),
    .store_addr_o (store_addr_o),
    .store_data_o (store_data_o)
  );

endmodule

//--- verification/cpu_tb.sv
module cpu_tb;
  import cpu_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 200;
  localparam int MAX_STEPS   = 100;
  localparam int NUM_REGS    = 1 << REGISTER_WIDTH;
  localparam int IMEM_AW     = $clog2(IMEM_SIZE);
  localparam int DMEM_AW     = $clog2(DMEM_SIZE);

  logic                      clk_i;
  logic                      rst_i;
  logic                      imem_we_i;
  logic [ADDR_WIDTH-1:0]     imem_addr_i;
  instruction_t              imem_data_i;
  logic [REGISTER_WIDTH-1:0] dbg_reg_sel_i;
  logic [DATA_WIDTH-1:0]     dbg_reg_data_o;
  logic                      retire_o;
  logic [ADDR_WIDTH-1:0]     retire_pc_o;
  logic                      store_o;
  logic [ADDR_WIDTH-1:0]     store_addr_o;
  logic [DATA_WIDTH-1:0]     store_data_o;

  instruction_t          prog [0:IMEM_SIZE-1];
  int                    prog_len;
  logic [31:0]           lcg_state;
  logic [DATA_WIDTH-1:0] m_regs [0:NUM_REGS-1];
  logic [DATA_WIDTH-1:0] m_dmem [0:DMEM_SIZE-1];
  logic [ADDR_WIDTH-1:0] exp_pcs [$];
  logic [ADDR_WIDTH-1:0] exp_st_addr [$];
  logic [DATA_WIDTH-1:0] exp_st_data [$];
  logic [ADDR_WIDTH-1:0] got_pcs [$];
  logic [ADDR_WIDTH-1:0] got_st_addr [$];
  logic [DATA_WIDTH-1:0] got_st_data [$];

  cpu dut0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .imem_we_i      (imem_we_i),
    .imem_addr_i    (imem_addr_i),
    .imem_data_i    (imem_data_i),
    .dbg_reg_sel_i  (dbg_reg_sel_i),
    .dbg_reg_data_o (dbg_reg_data_o),
    .retire_o       (retire_o),
    .retire_pc_o    (retire_pc_o),
    .store_o        (store_o),
    .store_addr_o   (store_addr_o),
    .store_data_o   (store_data_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ************************************************************
  // error reporting and compare tasks
  // ************************************************************
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_pc(input string name, input logic [ADDR_WIDTH-1:0] got,
                            input logic [ADDR_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_reg(input logic [REGISTER_WIDTH-1:0] idx,
                             input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH r%0d got %h expected %h", idx, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [IMM_WIDTH-1:0] random_imm();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];   // upper bits of the lcg are the better ones
  endfunction

  // ************************************************************
  // program building
  // ************************************************************
  function automatic instruction_t r_format(input opcode_e op, input logic [4:0] rd,
                                            input logic [4:0] ra, input logic [4:0] rb);
    instruction_t w;
    w          = '0;
    w.r.opcode = op;
    w.r.rd     = rd;
    w.r.ra     = ra;
    w.r.rb     = rb;
    return w;
  endfunction

  function automatic instruction_t i_format(input opcode_e op, input logic [4:0] rd,
                                            input logic [4:0] ra, input logic [15:0] imm);
    instruction_t w;
    w          = '0;
    w.i.opcode = op;
    w.i.rd     = rd;
    w.i.ra     = ra;
    w.i.imm    = imm;
    return w;
  endfunction

  task automatic clear_program();
    prog_len = 0;
    for (int i = 0; i < IMEM_SIZE; i++) prog[i] = '0;   // unused words decode as nop
  endtask

  task automatic append_instr(input instruction_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic pad_nops(input int n);
    prog_len = prog_len + n;
  endtask

  // ISA reference model, runs until the pc leaves the program
  task automatic run_model();
    instruction_t              w;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [ADDR_WIDTH-1:0]     next_pc;
    logic [DATA_WIDTH-1:0]     a;
    logic [DATA_WIDTH-1:0]     imm;
    logic [DATA_WIDTH-1:0]     addr;
    logic [DATA_WIDTH-1:0]     result;
    logic                      writes;
    int                        steps;
    exp_pcs.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    for (int r = 0; r < NUM_REGS; r++) m_regs[r] = '0;
    for (int d = 0; d < DMEM_SIZE; d++) m_dmem[d] = '0;
    pc    = '0;
    steps = 0;
    while (int'(pc) < prog_len && steps < MAX_STEPS) begin
      w       = prog[pc[IMEM_AW-1:0]];
      a       = m_regs[w.i.ra];
      imm     = {{(DATA_WIDTH-IMM_WIDTH){w.i.imm[IMM_WIDTH-1]}}, w.i.imm};
      addr    = a + imm;
      next_pc = pc + ADDR_WIDTH'(1);
      result  = '0;
      writes  = 1'b1;
      case (w.i.opcode)
        OP_ADD:  result = a + m_regs[w.r.rb];
        OP_SUB:  result = a - m_regs[w.r.rb];
        OP_AND:  result = a & m_regs[w.r.rb];
        OP_OR:   result = a | m_regs[w.r.rb];
        OP_ADDI: result = addr;
        OP_LW:   result = m_dmem[addr[DMEM_AW-1:0]];
        OP_SW: begin
          writes = 1'b0;
          m_dmem[addr[DMEM_AW-1:0]] = m_regs[w.i.rd];
          exp_st_addr.push_back(addr[ADDR_WIDTH-1:0]);
          exp_st_data.push_back(m_regs[w.i.rd]);
        end
        OP_BEQ: begin
          writes = 1'b0;
          if (a == m_regs[w.i.rd]) next_pc = pc + ADDR_WIDTH'(1) + imm[ADDR_WIDTH-1:0];
        end
        OP_JMP: begin
          writes  = 1'b0;
          next_pc = w.i.imm[ADDR_WIDTH-1:0];
        end
        default: writes = 1'b0;
      endcase
      if (writes && w.i.rd != '0) m_regs[w.i.rd] = result;   // rd has the same bits in both views
      exp_pcs.push_back(pc);
      pc = next_pc;
      steps++;
    end
  endtask

  // ************************************************************
  // reset, load and run
  // ************************************************************
  task automatic check_regs(input logic expect_zero);
    for (int r = 0; r < NUM_REGS; r++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      dbg_reg_sel_i = REGISTER_WIDTH'(r);
      @(negedge clk_i);
      compare_reg(REGISTER_WIDTH'(r), dbg_reg_data_o, expect_zero ? '0 : m_regs[r]);
    end
  endtask

  task automatic load_program();
    @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    for (int i = 0; i < IMEM_SIZE; i++) begin
      imem_we_i   = 1'b1;
      imem_addr_i = ADDR_WIDTH'(i);
      imem_data_i = prog[i];
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    imem_we_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      compare_bit("retire_o", retire_o, 1'b0);
      compare_bit("store_o", store_o, 1'b0);
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    check_regs(1'b1);
  endtask

  task automatic run_program();
    int waited;
    run_model();
    load_program();
    got_pcs.delete();
    got_st_addr.delete();
    got_st_data.delete();
    waited = 0;
    @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b1;
    while (got_pcs.size() < exp_pcs.size()) begin
      @(negedge clk_i);
      if (retire_o) got_pcs.push_back(retire_pc_o);
      if (store_o) begin
        got_st_addr.push_back(store_addr_o);
        got_st_data.push_back(store_data_o);
      end
      waited++;
      if (waited > TEST_CYCLES) fail_run("the core stopped retiring before the program ended");
    end
    @(posedge clk_i);   // write-back of the last instruction lands here
    #DRIVE_DELAY;
    for (int i = 0; i < exp_pcs.size(); i++) compare_pc("retire_pc_o", got_pcs[i], exp_pcs[i]);
    if (got_st_addr.size() != exp_st_addr.size()) begin
      fail_run($sformatf("expected %0d stores but saw %0d", exp_st_addr.size(),
                         got_st_addr.size()));
    end
    for (int i = 0; i < exp_st_addr.size(); i++) begin
      compare_pc("store_addr_o", got_st_addr[i], exp_st_addr[i]);
      compare_word("store_data_o", got_st_data[i], exp_st_data[i]);
    end
    check_regs(1'b0);
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************
  task automatic reset_test();
    clear_program();
    pad_nops(6);
    run_program();
  endtask

  task automatic arith_test();
    clear_program();
    append_instr(i_format(OP_ADDI, 1, 0, random_imm()));
    append_instr(i_format(OP_ADDI, 2, 0, random_imm()));
    pad_nops(3);
    append_instr(r_format(OP_ADD, 4, 1, 2));
    append_instr(r_format(OP_SUB, 5, 1, 2));
    append_instr(r_format(OP_AND, 6, 1, 2));
    append_instr(r_format(OP_OR, 7, 1, 2));
    append_instr(r_format(OP_ADD, 0, 1, 2));   // r0 must stay zero
    append_instr(i_format(OP_ADDI, 8, 1, random_imm()));
    pad_nops(2);
    append_instr(r_format(OP_SUB, 9, 4, 5));
    append_instr(r_format(OP_OR, 10, 6, 7));
    run_program();
  endtask

  task automatic mem_test();
    logic [31:0]          r;
    logic [IMM_WIDTH-1:0] base;
    logic [IMM_WIDTH-1:0] off;
    logic [IMM_WIDTH-1:0] other;
    r     = lcg_next();
    base  = IMM_WIDTH'(r[31:27]);
    off   = IMM_WIDTH'(r[26:22]);
    other = (base + off) ^ 16'h0020;   // a second word in range but never the first one
    clear_program();
    append_instr(i_format(OP_ADDI, 1, 0, random_imm()));
    append_instr(i_format(OP_ADDI, 2, 0, base));
    append_instr(i_format(OP_ADDI, 3, 0, random_imm()));
    pad_nops(3);
    append_instr(i_format(OP_SW, 1, 2, off));
    append_instr(i_format(OP_SW, 3, 0, other));
    append_instr(i_format(OP_LW, 4, 2, off));
    append_instr(i_format(OP_LW, 5, 0, other));
    pad_nops(3);
    append_instr(r_format(OP_ADD, 6, 4, 5));
    run_program();
  endtask

  task automatic branch_test();
    logic [IMM_WIDTH-1:0] v;
    v = random_imm();
    clear_program();
    append_instr(i_format(OP_ADDI, 1, 0, v));
    append_instr(i_format(OP_ADDI, 2, 0, v));
    append_instr(i_format(OP_ADDI, 3, 0, v ^ 16'h0001));
    pad_nops(3);
    append_instr(i_format(OP_BEQ, 2, 1, 16'd3));    // taken, lands on 10
    append_instr(i_format(OP_ADDI, 10, 0, 16'h00aa));
    append_instr(i_format(OP_ADDI, 11, 0, 16'h00bb));
    append_instr(i_format(OP_ADDI, 12, 0, 16'h00cc));
    append_instr(i_format(OP_BEQ, 3, 1, 16'd4));    // not taken
    append_instr(i_format(OP_ADDI, 13, 0, 16'h0013));
    append_instr(i_format(OP_ADDI, 14, 1, 16'h0001));
    append_instr(i_format(OP_BEQ, 0, 0, 16'd1));    // target is the second squashed slot
    append_instr(i_format(OP_ADDI, 15, 0, 16'h0015));
    append_instr(i_format(OP_ADDI, 16, 0, 16'h0016));
    run_program();
  endtask

  task automatic jump_test();
    clear_program();
    append_instr(i_format(OP_ADDI, 1, 0, random_imm()));
    append_instr(i_format(OP_JMP, 0, 0, 16'd5));
    append_instr(i_format(OP_ADDI, 20, 0, 16'h0020));
    append_instr(i_format(OP_ADDI, 21, 0, 16'h0021));
    append_instr(i_format(OP_ADDI, 22, 0, 16'h0022));
    append_instr(i_format(OP_ADDI, 2, 0, random_imm()));
    append_instr(i_format(OP_JMP, 0, 0, 16'd9));
    append_instr(i_format(OP_ADDI, 23, 0, 16'h0023));
    append_instr(i_format(OP_ADDI, 24, 0, 16'h0024));
    append_instr(i_format(OP_ADDI, 5, 1, random_imm()));
    pad_nops(2);
    append_instr(i_format(OP_JMP, 0, 0, 16'd14));
    append_instr(i_format(OP_ADDI, 25, 0, 16'h0025));
    append_instr(r_format(OP_ADD, 6, 2, 5));
    run_program();
  endtask

  initial begin
    lcg_state     = 32'h6959_d306;
    rst_i         = 1'b0;
    imem_we_i     = 1'b0;
    imem_addr_i   = '0;
    imem_data_i   = '0;
    dbg_reg_sel_i = '0;
    repeat (3) @(posedge clk_i);
    reset_test();
    arith_test();
    mem_test();
    branch_test();
    jump_test();
    $display("TEST RESULT: PASS");
    $finish;
  end

  // each test loads 64 words in reset and then runs a short program
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

//--- compile.f
hdl/cpu_pkg.sv
hdl/cpu_intf.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/rbank.sv
hdl/alu_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module cpu_tb \
  --Mdir obj_dir -o cpu_tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cpu_tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "no result line found in $LOG"
exit 1
